/* logic/llc_pkg.sv */
// shared sizes, vector types and descriptor structs of the llc hit/miss stage
// rtl modules and the testbench take these by a wildcard import
`default_nettype none

package llc_pkg;

  //////////////////////////////////////////////////
  // address layout and cache geometry
  //////////////////////////////////////////////////
  localparam int unsigned addr_width   = 32;
  localparam int unsigned id_width     = 4;
  // byte offset inside a line
  localparam int unsigned offset_width = 4;
  localparam int unsigned index_width  = 4;
  localparam int unsigned num_ways     = 4;
  // everything above index and offset
  localparam int unsigned tag_width    = addr_width - index_width - offset_width;
  localparam int unsigned num_sets     = 2 ** index_width;

  typedef logic [addr_width-1:0]  addr_t;
  typedef logic [id_width-1:0]    id_t;
  typedef logic [index_width-1:0] index_t;
  typedef logic [tag_width-1:0]   tag_t;
  // one-hot way select
  typedef logic [num_ways-1:0]    way_ind_t;

  //////////////////////////////////////////////////
  // descriptors and internal request structs
  //////////////////////////////////////////////////
  typedef struct packed {
    addr_t addr;
    id_t   id;
    // 1 means write
    logic  rw;
  } desc_in_t;

  typedef struct packed {
    addr_t    addr;
    id_t      id;
    logic     rw;
    way_ind_t way_ind;
    // line has to be fetched
    logic     refill;
    // victim is dirty and must be written back
    logic     evict;
    tag_t     evict_tag;
  } desc_out_t;

  typedef struct packed {
    index_t index;
    tag_t   tag;
    logic   dirty;
  } tag_req_t;

  typedef struct packed {
    way_ind_t way_ind;
    logic     hit;
    logic     evict;
    tag_t     evict_tag;
  } tag_res_t;

  // names a single cache line
  typedef struct packed {
    index_t   index;
    way_ind_t way_ind;
  } lock_t;

endpackage

`default_nettype wire

/* logic/llc_tag_store.sv */
// set-associative tag store with valid, dirty and round-robin state per set
// clears one set per cycle after reset, then answers one lookup per request
// a lookup also updates the arrays in the cycle the request is accepted
`default_nettype none

module llc_tag_store
  import llc_pkg::*;
(
  input  wire logic     clk_i,
  input  wire logic     rst_n_i,
  input  wire tag_req_t req_i,
  input  wire logic     req_valid_i,
  output logic          req_ready_o,
  output tag_res_t      res_o,
  output logic          res_valid_o,
  input  wire logic     res_ready_i
);

  typedef logic [$clog2(num_ways)-1:0] way_num_t;
  typedef enum logic {st_clear, st_ready} init_state_e;

  init_state_e state_q;
  index_t      clr_cnt_q;

  // storage arrays, one row per set
  tag_t        tag_q   [num_sets][num_ways];
  way_ind_t    valid_q [num_sets];
  way_ind_t    dirty_q [num_sets];
  way_num_t    rr_q    [num_sets];

  tag_res_t    res_q;
  logic        res_valid_q;

  way_ind_t    set_valid;
  way_ind_t    set_dirty;
  way_ind_t    hit_vec;
  logic        hit;
  logic        inv_found;
  way_num_t    hit_num;
  way_num_t    inv_num;
  way_num_t    sel_num;
  tag_res_t    lookup;
  logic        req_fire;

  //////////////////////////////////////////////////
  // lookup
  //////////////////////////////////////////////////
  assign set_valid = valid_q[req_i.index];
  assign set_dirty = dirty_q[req_i.index];

  // compare all ways, remember the lowest invalid one
  always_comb begin
    hit_vec   = '0;
    hit_num   = '0;
    inv_found = 1'b0;
    inv_num   = '0;
    for (int w = 0; w < num_ways; w++) begin
      if (set_valid[w] && (tag_q[req_i.index][w] == req_i.tag)) begin
        hit_vec[w] = 1'b1;
        hit_num    = way_num_t'(w);
      end
      if (!set_valid[w] && !inv_found) begin
        inv_found = 1'b1;
        inv_num   = way_num_t'(w);
      end
    end
  end

  assign hit = |hit_vec;
  // hit way first, then a free way, else the round-robin victim
  assign sel_num = hit ? hit_num : (inv_found ? inv_num : rr_q[req_i.index]);

  assign lookup.way_ind   = way_ind_t'(1) << sel_num;
  assign lookup.hit       = hit;
  assign lookup.evict     = !hit && set_valid[sel_num] && set_dirty[sel_num];
  assign lookup.evict_tag = tag_q[req_i.index][sel_num];

  // take a request only once the pending response leaves
  assign req_ready_o = (state_q == st_ready) && (!res_valid_q || res_ready_i);
  assign req_fire    = req_valid_i && req_ready_o;

  //////////////////////////////////////////////////
  // control state
  //////////////////////////////////////////////////
  always_ff @(posedge clk_i) begin
    if (!rst_n_i) begin
      state_q     <= st_clear;
      clr_cnt_q   <= '0;
      res_valid_q <= 1'b0;
    end else begin
      // init sweep over all sets
      if (state_q == st_clear) begin
        clr_cnt_q <= clr_cnt_q + 1'b1;
        if (clr_cnt_q == index_t'(num_sets - 1)) begin
          state_q <= st_ready;
        end
      end
      if (req_fire) begin
        res_valid_q <= 1'b1;
      end else if (res_ready_i) begin
        res_valid_q <= 1'b0;
      end
    end
  end

  //////////////////////////////////////////////////
  // arrays and response register
  //////////////////////////////////////////////////
  always_ff @(posedge clk_i) begin
    if (req_fire) begin
      res_q <= lookup;
    end
    if (state_q == st_clear) begin
      valid_q[clr_cnt_q] <= '0;
      dirty_q[clr_cnt_q] <= '0;
      rr_q[clr_cnt_q]    <= '0;
    end else if (req_fire) begin
      if (hit) begin
        // a write hit marks the line dirty
        dirty_q[req_i.index][sel_num] <= set_dirty[sel_num] | req_i.dirty;
      end else begin
        // refill target takes the new tag
        valid_q[req_i.index][sel_num] <= 1'b1;
        dirty_q[req_i.index][sel_num] <= req_i.dirty;
        tag_q[req_i.index][sel_num]   <= req_i.tag;
        if (!inv_found) begin
          rr_q[req_i.index] <= rr_q[req_i.index] + 1'b1;
        end
      end
    end
  end

  assign res_o       = res_q;
  assign res_valid_o = res_valid_q;

endmodule

`default_nettype wire

/* logic/llc_lock_table.sv */
// exact table of cache lines in use downstream
// a lock fills the lowest free entry, an unlock clears every matching entry
// locked_o flags a match on the probed line or a full table
`default_nettype none

module llc_lock_table
  import llc_pkg::*;
#(
  parameter int unsigned num_locks = 4
) (
  input  wire logic  clk_i,
  input  wire logic  rst_n_i,
  input  wire lock_t lock_i,
  input  wire logic  lock_req_i,
  output logic       locked_o,
  input  wire lock_t unlock_i,
  input  wire logic  unlock_valid_i
);

  logic [num_locks-1:0] ent_valid_q;
  lock_t                ent_q [num_locks];

  logic [num_locks-1:0] match_vec;
  logic [num_locks-1:0] unlock_vec;
  logic [num_locks-1:0] free_vec;
  logic                 free_found;

  //////////////////////////////////////////////////
  // match, unlock and free entry search
  //////////////////////////////////////////////////
  always_comb begin
    match_vec  = '0;
    unlock_vec = '0;
    free_vec   = '0;
    free_found = 1'b0;
    for (int i = 0; i < num_locks; i++) begin
      match_vec[i]  = ent_valid_q[i] && (ent_q[i] == lock_i);
      unlock_vec[i] = unlock_valid_i && ent_valid_q[i] && (ent_q[i] == unlock_i);
      // lowest free slot wins
      if (!ent_valid_q[i] && !free_found) begin
        free_vec[i] = 1'b1;
        free_found  = 1'b1;
      end
    end
  end

  // a full table blocks every line
  assign locked_o = (|match_vec) || (&ent_valid_q);

  // valid bits; unlock and lock of one cycle both apply
  always_ff @(posedge clk_i) begin
    if (!rst_n_i) begin
      ent_valid_q <= '0;
    end else begin
      ent_valid_q <= (ent_valid_q & ~unlock_vec) | (lock_req_i ? free_vec : '0);
    end
  end

  // entry payload
  always_ff @(posedge clk_i) begin
    for (int i = 0; i < num_locks; i++) begin
      if (lock_req_i && free_vec[i]) begin
        ent_q[i] <= lock_i;
      end
    end
  end

endmodule

`default_nettype wire

/* logic/llc_hit_miss_ctrl.sv */
// descriptor control of the hit/miss stage
// issues the tag lookup as a descriptor enters, then routes the held one
// to the hit or miss output once the tag result is back and the line is free
`default_nettype none

module llc_hit_miss_ctrl
  import llc_pkg::*;
(
  input  wire logic     clk_i,
  input  wire logic     rst_n_i,
  input  wire desc_in_t desc_i,
  input  wire logic     valid_i,
  output logic          ready_o,
  output desc_out_t     desc_o,
  output logic          hit_valid_o,
  input  wire logic     hit_ready_i,
  output logic          miss_valid_o,
  input  wire logic     miss_ready_i,
  output tag_req_t      tag_req_o,
  output logic          tag_req_valid_o,
  input  wire logic     tag_req_ready_i,
  input  wire tag_res_t tag_res_i,
  input  wire logic     tag_res_valid_i,
  output logic          tag_res_ready_o,
  output lock_t         lock_o,
  output logic          lock_req_o,
  input  wire logic     locked_i
);

  // a descriptor sits in the unit waiting for its result
  logic     busy_q;
  desc_in_t desc_q;

  logic     can_take;
  logic     accept;
  logic     out_valid;
  logic     xfer;

  //////////////////////////////////////////////////
  // input side and tag request
  //////////////////////////////////////////////////
  assign tag_req_o.index = desc_i.addr[offset_width +: index_width];
  assign tag_req_o.tag   = desc_i.addr[offset_width + index_width +: tag_width];
  assign tag_req_o.dirty = desc_i.rw;

  // free slot, or the held descriptor leaves this cycle
  assign can_take        = !busy_q || xfer;
  assign tag_req_valid_o = valid_i && can_take;
  // tag store is not ready during its init sweep
  assign ready_o         = can_take && tag_req_ready_i;
  assign accept          = valid_i && ready_o;

  //////////////////////////////////////////////////
  // output side
  //////////////////////////////////////////////////
  // held descriptor merged with the lookup result
  assign desc_o.addr      = desc_q.addr;
  assign desc_o.id        = desc_q.id;
  assign desc_o.rw        = desc_q.rw;
  assign desc_o.way_ind   = tag_res_i.way_ind;
  assign desc_o.refill    = !tag_res_i.hit;
  assign desc_o.evict     = tag_res_i.evict;
  assign desc_o.evict_tag = tag_res_i.evict_tag;

  // line the result names
  assign lock_o.index   = desc_q.addr[offset_width +: index_width];
  assign lock_o.way_ind = tag_res_i.way_ind;

  // stall while the line is still in use downstream
  assign out_valid    = busy_q && tag_res_valid_i && !locked_i;
  assign hit_valid_o  = out_valid && tag_res_i.hit;
  assign miss_valid_o = out_valid && !tag_res_i.hit;

  assign xfer = (hit_valid_o && hit_ready_i) || (miss_valid_o && miss_ready_i);

  // result consumed and line locked on every transfer
  assign tag_res_ready_o = xfer;
  assign lock_req_o      = xfer;

  always_ff @(posedge clk_i) begin
    if (!rst_n_i) begin
      busy_q <= 1'b0;
    end else if (accept) begin
      busy_q <= 1'b1;
    end else if (xfer) begin
      // nothing new behind it, go idle
      busy_q <= 1'b0;
    end
  end

  // descriptor register
  always_ff @(posedge clk_i) begin
    if (accept) begin
      desc_q <= desc_i;
    end
  end

endmodule

`default_nettype wire

/* logic/llc_hit_miss.sv */
// top of the llc hit/miss stage
// connects the descriptor control to the tag store and the lock table
`default_nettype none

module llc_hit_miss
  import llc_pkg::*;
#(
  // depth of the lock table
  parameter int unsigned num_locks = 4
) (
  input  wire logic     clk_i,
  input  wire logic     rst_n_i,
  input  wire desc_in_t desc_i,
  input  wire logic     valid_i,
  output logic          ready_o,
  output desc_out_t     desc_o,
  output logic          hit_valid_o,
  input  wire logic     hit_ready_i,
  output logic          miss_valid_o,
  input  wire logic     miss_ready_i,
  input  wire lock_t    unlock_i,
  input  wire logic     unlock_valid_i
);

  // control to tag store
  tag_req_t tag_req;
  logic     tag_req_valid;
  logic     tag_req_ready;
  tag_res_t tag_res;
  logic     tag_res_valid;
  logic     tag_res_ready;

  // control to lock table
  lock_t    lock;
  logic     lock_req;
  logic     locked;

  llc_hit_miss_ctrl u_ctrl (
    .clk_i           (clk_i),
    .rst_n_i         (rst_n_i),
    .desc_i          (desc_i),
    .valid_i         (valid_i),
    .ready_o         (ready_o),
    .desc_o          (desc_o),
    .hit_valid_o     (hit_valid_o),
    .hit_ready_i     (hit_ready_i),
    .miss_valid_o    (miss_valid_o),
    .miss_ready_i    (miss_ready_i),
    .tag_req_o       (tag_req),
    .tag_req_valid_o (tag_req_valid),
    .tag_req_ready_i (tag_req_ready),
    .tag_res_i       (tag_res),
    .tag_res_valid_i (tag_res_valid),
    .tag_res_ready_o (tag_res_ready),
    .lock_o          (lock),
    .lock_req_o      (lock_req),
    .locked_i        (locked)
  );

  llc_tag_store u_tag_store (
    .clk_i       (clk_i),
    .rst_n_i     (rst_n_i),
    .req_i       (tag_req),
    .req_valid_i (tag_req_valid),
    .req_ready_o (tag_req_ready),
    .res_o       (tag_res),
    .res_valid_o (tag_res_valid),
    .res_ready_i (tag_res_ready)
  );

  llc_lock_table #(
    .num_locks (num_locks)
  ) u_lock_table (
    .clk_i          (clk_i),
    .rst_n_i        (rst_n_i),
    .lock_i         (lock),
    .lock_req_i     (lock_req),
    .locked_o       (locked),
    .unlock_i       (unlock_i),
    .unlock_valid_i (unlock_valid_i)
  );

endmodule

`default_nettype wire

/* tests/llc_hm_tests.svh */
// directed tests of the llc hit/miss stage
// included inside the testbench module, uses its helpers and reference model
`ifndef LLC_HM_TESTS_SVH
`define LLC_HM_TESTS_SVH

//////////////////////////////////////////////////
// init sweep, then misses into empty sets
//////////////////////////////////////////////////
task automatic init_sweep_check();
  way_ind_t way;
  int       waited;
  // valid_i goes up right as reset lifts
  run_access("init_sweep", make_addr(tag_t'(rand_bits(tag_width)), index_t'(1)),
             id_t'(1), 1'b0, 1'b1, way, waited);
  if (waited != num_sets) flag_mismatch("init_sweep", "cycles with ready_o low", num_sets, waited);
  if (way != way_ind_t'(1)) flag_mismatch("init_sweep", "first way", 32'(1), 32'(way));
  run_access("init_sweep", make_addr(tag_t'(rand_bits(tag_width)), index_t'(1)),
             id_t'(2), 1'b1, 1'b1, way, waited);
  if (way != way_ind_t'(2)) flag_mismatch("init_sweep", "second way", 32'(2), 32'(way));
  run_access("init_sweep", make_addr(tag_t'(rand_bits(tag_width)), index_t'(0)),
             id_t'(3), 1'b0, 1'b1, way, waited);
endtask

task automatic hit_after_miss();
  addr_t    addr;
  way_ind_t miss_way;
  way_ind_t hit_way;
  int       waited;
  addr = make_addr(tag_t'(rand_bits(tag_width)), index_t'(4));
  run_access("hit_after_miss", addr, id_t'(4), 1'b0, 1'b1, miss_way, waited);
  run_access("hit_after_miss", addr, id_t'(5), 1'b0, 1'b1, hit_way, waited);
  if (hit_way != miss_way) flag_mismatch("hit_after_miss", "hit way", 32'(miss_way), 32'(hit_way));
endtask

// six writes to one set; the fifth and sixth evict ways 0 and 1
task automatic round_robin_evict(input string name, input index_t idx, input bit use_lfsr);
  tag_t     tag;
  way_ind_t way;
  int       waited;
  int       k;
  for (k = 0; k < 6; k++) begin
    tag = use_lfsr ? tag_t'(rand_bits(tag_width)) : tag_t'(k + 'h0c00);
    run_access(name, make_addr(tag, idx), id_t'(k), 1'b1, 1'b1, way, waited);
    if (k >= 4 && way != (way_ind_t'(1) << (k - 4))) begin
      flag_mismatch(name, "victim way", 32'(way_ind_t'(1) << (k - 4)), 32'(way));
    end
  end
endtask

//////////////////////////////////////////////////
// locked line and back-pressure
//////////////////////////////////////////////////
task automatic lock_stall();
  addr_t    addr;
  way_ind_t way;
  way_ind_t exp_way;
  logic     exp_hit;
  logic     exp_evict;
  logic     seen;
  tag_t     exp_etag;
  int       waited;
  int       i;
  addr = make_addr(tag_t'(rand_bits(tag_width)), index_t'(5));
  // line stays locked after this one
  run_access("lock_stall", addr, id_t'(6), 1'b1, 1'b0, way, waited);
  predict(addr, 1'b0, exp_hit, exp_way, exp_evict, exp_etag);
  send_desc(addr, id_t'(7), 1'b0, waited);
  for (i = 0; i < stall_cycles; i++) begin
    #1;
    if (hit_valid_o || miss_valid_o) begin
      note_failure("lock_stall: output valid raised while the line was still locked");
    end
    @(negedge clk_i);
  end
  release_line(addr, way);
  wait_valid("lock_stall", seen);
  if (seen) check_desc("lock_stall", addr, id_t'(7), 1'b0, exp_hit, exp_way, exp_evict, exp_etag);
  @(negedge clk_i);
  release_line(addr, exp_way);
endtask

// hold one result with both readies low, then let it go
task automatic stall_output(input string name, input addr_t addr, input logic rw);
  way_ind_t  exp_way;
  desc_out_t held;
  logic      exp_hit;
  logic      exp_evict;
  logic      seen;
  tag_t      exp_etag;
  int        waited;
  int        i;
  predict(addr, rw, exp_hit, exp_way, exp_evict, exp_etag);
  hit_ready_i  = 1'b0;
  miss_ready_i = 1'b0;
  send_desc(addr, id_t'(9), rw, waited);
  wait_valid(name, seen);
  held = desc_o;
  for (i = 0; i < 4; i++) begin
    @(negedge clk_i);
    #1;
    if (desc_o != held) note_failure($sformatf("%s: desc_o changed while stalled", name));
    if (hit_valid_o != exp_hit || miss_valid_o == exp_hit) begin
      note_failure($sformatf("%s: output valid dropped while stalled", name));
    end
    if (ready_o) note_failure($sformatf("%s: ready_o high while the output was stalled", name));
  end
  @(negedge clk_i);
  hit_ready_i  = 1'b1;
  miss_ready_i = 1'b1;
  #1;
  if (seen) check_desc(name, addr, id_t'(9), rw, exp_hit, exp_way, exp_evict, exp_etag);
  @(negedge clk_i);
  #1;
  if (hit_valid_o || miss_valid_o) note_failure($sformatf("%s: more than one transfer", name));
  @(negedge clk_i);
  release_line(addr, exp_way);
endtask

task automatic back_pressure();
  addr_t addr;
  addr = make_addr(tag_t'(rand_bits(tag_width)), index_t'(7));
  stall_output("bp_miss", addr, 1'b1);
  stall_output("bp_hit", addr, 1'b0);
endtask

`endif

/* tests/tb_llc_hit_miss.sv */
// testbench top for the llc hit/miss stage
// drives descriptors into UUT and checks both outputs against a reference tag model
// the directed tests sit in the included test file and run from the initial block below
`default_nettype none

module tb_llc_hit_miss
  import llc_pkg::*;
();

  localparam int timeout_cycles = 64;
  localparam int stall_cycles   = 8;

  logic      clk_i;
  logic      rst_n_i;
  desc_in_t  desc_i;
  logic      valid_i;
  logic      ready_o;
  desc_out_t desc_o;
  logic      hit_valid_o;
  logic      hit_ready_i;
  logic      miss_valid_o;
  logic      miss_ready_i;
  lock_t     unlock_i;
  logic      unlock_valid_i;

  int          errors;
  logic [31:0] lfsr_q;

  // reference model of the tag store
  tag_t     m_tag   [num_sets][num_ways];
  way_ind_t m_valid [num_sets];
  way_ind_t m_dirty [num_sets];
  int       m_rr    [num_sets];

  llc_hit_miss #(
    .num_locks (4)
  ) UUT (
    .clk_i          (clk_i),
    .rst_n_i        (rst_n_i),
    .desc_i         (desc_i),
    .valid_i        (valid_i),
    .ready_o        (ready_o),
    .desc_o         (desc_o),
    .hit_valid_o    (hit_valid_o),
    .hit_ready_i    (hit_ready_i),
    .miss_valid_o   (miss_valid_o),
    .miss_ready_i   (miss_ready_i),
    .unlock_i       (unlock_i),
    .unlock_valid_i (unlock_valid_i)
  );

  initial begin
    clk_i = 1'b0;
    forever #2 clk_i = ~clk_i;
  end

  //////////////////////////////////////////////////
  // reference model
  //////////////////////////////////////////////////
  function automatic void model_reset();
    for (int s = 0; s < num_sets; s++) begin
      m_valid[s] = '0;
      m_dirty[s] = '0;
      m_rr[s]    = 0;
    end
  endfunction

  // expected lookup result, then the array update of the same access
  function automatic void predict(input addr_t addr, input logic rw, output logic hit,
                                  output way_ind_t way, output logic evict, output tag_t etag);
    index_t idx;
    tag_t   tag;
    int     sel;
    int     w;
    idx = addr[offset_width +: index_width];
    tag = addr[offset_width + index_width +: tag_width];
    sel = -1;
    hit = 1'b0;
    for (w = 0; w < num_ways; w++) begin
      if (m_valid[idx][w] && (m_tag[idx][w] == tag)) begin
        hit = 1'b1;
        sel = w;
      end
    end
    if (!hit) begin
      // walking down leaves the lowest invalid way
      for (w = num_ways - 1; w >= 0; w--) begin
        if (!m_valid[idx][w]) begin
          sel = w;
        end
      end
      if (sel < 0) begin
        sel       = m_rr[idx];
        m_rr[idx] = (m_rr[idx] + 1) % num_ways;
      end
    end
    way      = '0;
    way[sel] = 1'b1;
    evict    = !hit && m_valid[idx][sel] && m_dirty[idx][sel];
    etag     = m_tag[idx][sel];
    if (hit) begin
      m_dirty[idx][sel] = m_dirty[idx][sel] | rw;
    end else begin
      m_valid[idx][sel] = 1'b1;
      m_dirty[idx][sel] = rw;
      m_tag[idx][sel]   = tag;
    end
  endfunction

  //////////////////////////////////////////////////
  // stimulus and check helpers
  //////////////////////////////////////////////////
  // fibonacci lfsr with taps 32 22 2 1 stepped once per bit
  function automatic logic [31:0] rand_bits(input int n);
    logic [31:0] val;
    logic        fb;
    int          i;
    val = '0;
    for (i = 0; i < n; i++) begin
      fb     = lfsr_q[31] ^ lfsr_q[21] ^ lfsr_q[1] ^ lfsr_q[0];
      lfsr_q = {lfsr_q[30:0], fb};
      val    = {val[30:0], fb};
    end
    return val;
  endfunction

  function automatic addr_t make_addr(input tag_t tag, input index_t idx);
    return {tag, idx, {offset_width{1'b0}}};
  endfunction

  task automatic flag_mismatch(input string name, input string field,
                               input logic [31:0] exp, input logic [31:0] act);
    errors++;
    $display("[ERROR] %s: %s expected %0h got %0h", name, field, exp, act);
  endtask

  task automatic note_failure(input string msg);
    errors++;
    $display("%s", msg);
  endtask

  // entered on a falling edge, returns on the falling edge after acceptance
  task automatic send_desc(input addr_t addr, input id_t id, input logic rw, output int waited);
    desc_i.addr = addr;
    desc_i.id   = id;
    desc_i.rw   = rw;
    valid_i     = 1'b1;
    waited      = 0;
    #1;
    while (!ready_o && waited < timeout_cycles) begin
      @(negedge clk_i);
      #1;
      waited++;
    end
    if (!ready_o) begin
      note_failure($sformatf("timeout: descriptor for address %h never accepted", addr));
    end
    @(negedge clk_i);
    valid_i = 1'b0;
  endtask

  // returns just after a falling edge with an output valid raised
  task automatic wait_valid(input string name, output logic seen);
    int cyc;
    cyc = 0;
    #1;
    while (!(hit_valid_o || miss_valid_o) && cyc < timeout_cycles) begin
      @(negedge clk_i);
      #1;
      cyc++;
    end
    seen = hit_valid_o || miss_valid_o;
    if (!seen) begin
      note_failure($sformatf("%s: timeout, no output valid after the lookup", name));
    end
  endtask

  task automatic check_desc(input string name, input addr_t addr, input id_t id, input logic rw,
                            input logic exp_hit, input way_ind_t exp_way, input logic exp_evict,
                            input tag_t exp_etag);
    if (hit_valid_o != exp_hit) begin
      flag_mismatch(name, "hit_valid_o", 32'(exp_hit), 32'(hit_valid_o));
    end
    if (miss_valid_o == exp_hit) begin
      flag_mismatch(name, "miss_valid_o", 32'(!exp_hit), 32'(miss_valid_o));
    end
    if (desc_o.addr != addr) begin
      flag_mismatch(name, "addr", addr, desc_o.addr);
    end
    if (desc_o.id != id) begin
      flag_mismatch(name, "id", 32'(id), 32'(desc_o.id));
    end
    if (desc_o.rw != rw) begin
      flag_mismatch(name, "rw", 32'(rw), 32'(desc_o.rw));
    end
    if (desc_o.way_ind != exp_way) begin
      flag_mismatch(name, "way_ind", 32'(exp_way), 32'(desc_o.way_ind));
    end
    if (desc_o.refill == exp_hit) begin
      flag_mismatch(name, "refill", 32'(!exp_hit), 32'(desc_o.refill));
    end
    if (desc_o.evict != exp_evict) begin
      flag_mismatch(name, "evict", 32'(exp_evict), 32'(desc_o.evict));
    end
    // tag of a never written way is meaningless
    if (exp_evict && desc_o.evict_tag != exp_etag) begin
      flag_mismatch(name, "evict_tag", 32'(exp_etag), 32'(desc_o.evict_tag));
    end
  endtask

  task automatic release_line(input addr_t addr, input way_ind_t way);
    unlock_i.index   = addr[offset_width +: index_width];
    unlock_i.way_ind = way;
    unlock_valid_i   = 1'b1;
    @(negedge clk_i);
    unlock_valid_i   = 1'b0;
  endtask

  // one full access with both readies high, optionally unlocking the line afterwards
  // way returns the line the DUT reported
  task automatic run_access(input string name, input addr_t addr, input id_t id, input logic rw,
                            input bit unlock, output way_ind_t way, output int waited);
    logic     exp_hit;
    logic     exp_evict;
    logic     seen;
    tag_t     exp_etag;
    way_ind_t exp_way;
    predict(addr, rw, exp_hit, exp_way, exp_evict, exp_etag);
    send_desc(addr, id, rw, waited);
    wait_valid(name, seen);
    way = exp_way;
    if (seen) begin
      check_desc(name, addr, id, rw, exp_hit, exp_way, exp_evict, exp_etag);
      way = desc_o.way_ind;
    end
    @(negedge clk_i);
    if (unlock) begin
      release_line(addr, way);
    end
  endtask

  `include "llc_hm_tests.svh"

  //////////////////////////////////////////////////
  // test sequence
  //////////////////////////////////////////////////
  initial begin
    errors         = 0;
    lfsr_q         = 32'hb6ba38ae;
    rst_n_i        = 1'b0;
    desc_i         = '0;
    valid_i        = 1'b0;
    hit_ready_i    = 1'b1;
    miss_ready_i   = 1'b1;
    unlock_i       = '0;
    unlock_valid_i = 1'b0;
    model_reset();
    repeat (16) @(negedge clk_i);
    rst_n_i = 1'b1;
    init_sweep_check();
    hit_after_miss();
    round_robin_evict("rr_fixed", index_t'(2), 1'b0);
    round_robin_evict("rr_random", index_t'(3), 1'b1);
    lock_stall();
    back_pressure();
    $display("errors: %0d", errors);
    if (errors == 0) begin
      $display("Result: PASSED");
    end else begin
      $display("Result: FAILED");
    end
    $finish;
  end

endmodule

`default_nettype wire

/* filelist.f */
+incdir+tests
logic/llc_pkg.sv
logic/llc_tag_store.sv
logic/llc_lock_table.sv
logic/llc_hit_miss_ctrl.sv
logic/llc_hit_miss.sv
tests/tb_llc_hit_miss.sv

/* Makefile */
# Verilator build, run and lint of the llc hit/miss testbench
VERILATOR  ?= verilator
FLAGS      ?= --binary --timing -j 0
LINT_FLAGS ?= --lint-only --timing
TOP        ?= tb_llc_hit_miss
FILELIST   ?= filelist.f
OBJ_DIR    ?= obj_dir
LOG        ?= sim.log

.PHONY: all build run lint clean

all: run

build:
	$(VERILATOR) $(FLAGS) --top-module $(TOP) -f $(FILELIST) --Mdir $(OBJ_DIR)

run: build
	./$(OBJ_DIR)/V$(TOP) > $(LOG) 2>&1; status=$$?; cat $(LOG); exit $$status
	@if grep -q "Result: FAILED" $(LOG); then exit 1; fi

lint:
	$(VERILATOR) $(LINT_FLAGS) --top-module $(TOP) -f $(FILELIST)

clean:
	rm -rf $(OBJ_DIR) $(LOG)
